// ==== design/mul_pkg.sv ====
/*
  Multiply unit package
  Word widths, nibble array geometry, pipeline latency, vector types,
  configuration register map and the request controller states
*/

package mul_pkg;

  // Operand and result width of the unit
  localparam int WORD_WIDTH = 32;

  // One digit of the nibble array
  localparam int NIBBLE_WIDTH = 4;

  // Digits per operand, so the array holds NIBBLES * NIBBLES products
  localparam int NIBBLES = WORD_WIDTH / NIBBLE_WIDTH;

  // Clock edges from issue to prod_valid in the multiplier
  localparam int MUL_LATENCY = 4;

  // Width of the completion counter
  localparam int CNT_WIDTH = 16;

  // Width of the configuration register address
  localparam int CFG_ADDR_WIDTH = 2;

  typedef logic [WORD_WIDTH-1:0]     word_t;
  typedef logic [2*WORD_WIDTH-1:0]   dword_t;
  typedef logic [CNT_WIDTH-1:0]      cnt_t;
  typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

  // Register map of the configuration block
  localparam cfg_addr_t REG_CTRL   = 2'd0;
  localparam cfg_addr_t REG_STATUS = 2'd1;
  localparam cfg_addr_t REG_COUNT  = 2'd2;

  // Handshake states of the request controller
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } ctrl_state_t;

endpackage

// ==== design/nibble_multiplier.sv ====
/*
  Nibble array multiplier
  Four stage pipelined unsigned 32x32 multiply built from 4-bit digit
  products and an adder tree, returning the low word and an overflow bit
*/

`timescale 1ns/10ps

module nibble_multiplier (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           issue,
  input  mul_pkg::word_t issue_a,
  input  mul_pkg::word_t issue_b,
  output logic           prod_valid,
  output mul_pkg::word_t prod_lo,
  output logic           prod_ovf
);

  localparam int NW       = mul_pkg::NIBBLE_WIDTH;
  localparam int NN       = mul_pkg::NIBBLES;
  localparam int TERMS    = NN * NN;
  localparam int GROUPS_2 = TERMS / 4;
  localparam int GROUPS_3 = GROUPS_2 / 4;

  // Stage 1 operand registers
  mul_pkg::word_t a_q;
  mul_pkg::word_t b_q;

  // Shifted digit products, combinational from the stage 1 registers
  mul_pkg::dword_t terms [TERMS];

  // Adder tree levels registered at stages 2 and 3
  mul_pkg::dword_t sum2 [GROUPS_2];
  mul_pkg::dword_t sum3 [GROUPS_3];

  // Final sum feeding the output split of stage 4
  mul_pkg::dword_t total;

  // Valid bit for each stage, the last one is prod_valid
  logic [mul_pkg::MUL_LATENCY-1:0] valid_pipe;

  // One digit product placed at its weight in the 64-bit result
  function automatic mul_pkg::dword_t nibble_term(
    input logic [NW-1:0] x,
    input logic [NW-1:0] y,
    input int            weight
  );
    logic [2*NW-1:0] digit_prod;
    mul_pkg::dword_t placed;
    digit_prod = {{NW{1'b0}}, x} * {{NW{1'b0}}, y};
    placed = '0;
    placed[2*NW-1:0] = digit_prod;
    return placed << (weight * NW);
  endfunction

  // The valid bit walks beside the data so each stage can hold its own op
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_pipe <= '0;
    end
    else
    begin
      valid_pipe <= {valid_pipe[mul_pkg::MUL_LATENCY-2:0], issue};
    end
  end

  assign prod_valid = valid_pipe[mul_pkg::MUL_LATENCY-1];

  // Stage 1 captures the operands on issue
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      a_q <= issue_a;
      b_q <= issue_b;
    end
  end

  // Every digit of a against every digit of b, weight is the sum of positions
  always_comb
  begin
    for (int i = 0; i < NN; i++)
    begin
      for (int j = 0; j < NN; j++)
      begin
        terms[i*NN+j] = nibble_term(a_q[i*NW +: NW], b_q[j*NW +: NW], i + j);
      end
    end
  end

  // Stage 2 reduces the 64 terms in groups of four
  // Full 64-bit width everywhere, so no level can carry out
  always_ff @(posedge clk)
  begin
    for (int g = 0; g < GROUPS_2; g++)
    begin
      sum2[g] <= terms[4*g] + terms[4*g+1] + terms[4*g+2] + terms[4*g+3];
    end
  end

  // Stage 3 folds the 16 partial sums down to 4
  always_ff @(posedge clk)
  begin
    for (int h = 0; h < GROUPS_3; h++)
    begin
      sum3[h] <= sum2[4*h] + sum2[4*h+1] + sum2[4*h+2] + sum2[4*h+3];
    end
  end

  // Last level of the tree feeds the output registers directly
  always_comb
  begin
    total = '0;
    for (int k = 0; k < GROUPS_3; k++)
    begin
      total = total + sum3[k];
    end
  end

  // Stage 4 splits the product, any bit in the high word means overflow
  always_ff @(posedge clk)
  begin
    prod_lo  <= total[mul_pkg::WORD_WIDTH-1:0];
    prod_ovf <= |total[2*mul_pkg::WORD_WIDTH-1:mul_pkg::WORD_WIDTH];
  end

endmodule

// ==== design/mul_req_ctrl.sv ====
/*
  Multiply request controller
  Runs the four-phase req/ack handshake, issues operands to the multiplier,
  applies saturation and holds the result until req is released
*/

`timescale 1ns/10ps

module mul_req_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req,
  input  mul_pkg::word_t op_a,
  input  mul_pkg::word_t op_b,
  output logic           ack,
  output mul_pkg::word_t result,
  output logic           ovf,
  input  logic           sat_en,
  output logic           issue,
  output mul_pkg::word_t issue_a,
  output mul_pkg::word_t issue_b,
  input  logic           prod_valid,
  input  mul_pkg::word_t prod_lo,
  input  logic           prod_ovf,
  output logic           done,
  output logic           done_ovf
);

  mul_pkg::ctrl_state_t state;

  // A new request is taken only from IDLE, where ack is already low
  logic accept;

  // The single outstanding operation has come back from the multiplier
  logic complete;

  assign accept   = (state == mul_pkg::IDLE) && req;
  assign complete = (state == mul_pkg::BUSY) && prod_valid;

  // Handshake FSM
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= mul_pkg::IDLE;
      issue <= 1'b0;
      ack   <= 1'b0;
      done  <= 1'b0;
    end
    else
    begin
      // issue and done are single cycle strobes
      issue <= 1'b0;
      done  <= 1'b0;
      case (state)
        mul_pkg::IDLE:
        begin
          if (accept)
          begin
            issue <= 1'b1;
            state <= mul_pkg::BUSY;
          end
        end
        mul_pkg::BUSY:
        begin
          if (complete)
          begin
            ack   <= 1'b1;
            done  <= 1'b1;
            state <= mul_pkg::DONE;
          end
        end
        mul_pkg::DONE:
        begin
          // Result and ack stay put for as long as the requester holds req
          if (!req)
          begin
            ack   <= 1'b0;
            state <= mul_pkg::IDLE;
          end
        end
        default:
        begin
          state <= mul_pkg::IDLE;
        end
      endcase
    end
  end

  // Operands are captured at the accepting edge and stay on the issue bus
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      issue_a <= op_a;
      issue_b <= op_b;
    end
  end

  // Saturation replaces the low word with all ones only on overflow
  always_ff @(posedge clk)
  begin
    if (complete)
    begin
      result   <= (sat_en && prod_ovf) ? '1 : prod_lo;
      ovf      <= prod_ovf;
      done_ovf <= prod_ovf;
    end
  end

endmodule

// ==== design/mul_config_regs.sv ====
/*
  Multiply unit configuration and status registers
  Saturate mode control, sticky overflow flag and completion counter
*/

`timescale 1ns/10ps

module mul_config_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_wr,
  input  mul_pkg::cfg_addr_t cfg_addr,
  input  mul_pkg::word_t     cfg_wdata,
  output mul_pkg::word_t     cfg_rdata,
  output logic               sat_en,
  input  logic               done,
  input  logic               done_ovf
);

  // Sticky overflow flag held in STATUS bit 0
  logic ovf_flag;

  // Completed multiplies since reset
  mul_pkg::cnt_t done_count;

  // Write strobes decoded per register
  logic wr_ctrl;
  logic wr_status;

  assign wr_ctrl   = cfg_wr && (cfg_addr == mul_pkg::REG_CTRL);
  assign wr_status = cfg_wr && (cfg_addr == mul_pkg::REG_STATUS);

  // CTRL bit 0 turns on saturation in the controller
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sat_en <= 1'b0;
    end
    else if (wr_ctrl)
    begin
      sat_en <= cfg_wdata[0];
    end
  end

  // An overflowing completion beats a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ovf_flag <= 1'b0;
    end
    else if (done && done_ovf)
    begin
      ovf_flag <= 1'b1;
    end
    else if (wr_status && cfg_wdata[0])
    begin
      ovf_flag <= 1'b0;
    end
  end

  // COUNT is read only and simply wraps
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      done_count <= '0;
    end
    else if (done)
    begin
      done_count <= done_count + mul_pkg::cnt_t'(1);
    end
  end

  // Combinational readback where unmapped addresses return zero
  always_comb
  begin
    cfg_rdata = '0;
    case (cfg_addr)
      mul_pkg::REG_CTRL:   cfg_rdata[0] = sat_en;
      mul_pkg::REG_STATUS: cfg_rdata[0] = ovf_flag;
      mul_pkg::REG_COUNT:  cfg_rdata[mul_pkg::CNT_WIDTH-1:0] = done_count;
      default:             cfg_rdata = '0;
    endcase
  end

endmodule

// ==== design/mul_unit_top.sv ====
/*
  Integer multiply unit
  Request controller, nibble array multiplier and configuration registers
*/

`timescale 1ns/10ps

module mul_unit_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req,
  input  mul_pkg::word_t     op_a,
  input  mul_pkg::word_t     op_b,
  output logic               ack,
  output mul_pkg::word_t     result,
  output logic               ovf,
  input  logic               cfg_wr,
  input  mul_pkg::cfg_addr_t cfg_addr,
  input  mul_pkg::word_t     cfg_wdata,
  output mul_pkg::word_t     cfg_rdata
);

  // Controller to multiplier
  logic           issue;
  mul_pkg::word_t issue_a;
  mul_pkg::word_t issue_b;

  // Multiplier back to controller
  logic           prod_valid;
  mul_pkg::word_t prod_lo;
  logic           prod_ovf;

  // Between controller and register block
  logic sat_en;
  logic done;
  logic done_ovf;

  mul_req_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .op_a       (op_a),
    .op_b       (op_b),
    .ack        (ack),
    .result     (result),
    .ovf        (ovf),
    .sat_en     (sat_en),
    .issue      (issue),
    .issue_a    (issue_a),
    .issue_b    (issue_b),
    .prod_valid (prod_valid),
    .prod_lo    (prod_lo),
    .prod_ovf   (prod_ovf),
    .done       (done),
    .done_ovf   (done_ovf)
  );

  nibble_multiplier u_mul (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_a    (issue_a),
    .issue_b    (issue_b),
    .prod_valid (prod_valid),
    .prod_lo    (prod_lo),
    .prod_ovf   (prod_ovf)
  );

  mul_config_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .sat_en    (sat_en),
    .done      (done),
    .done_ovf  (done_ovf)
  );

endmodule

// ==== dv/mul_unit_asserts.sv ====
/*
  Multiply unit assertions
  Handshake rules, request to ack latency, product and saturation, and the
  status register updates, bound into the top level
*/

`timescale 1ns/10ps

module mul_unit_asserts (
  input logic           clk,
  input logic           rst_n,
  input logic           req,
  input mul_pkg::word_t op_a,
  input mul_pkg::word_t op_b,
  input logic           ack,
  input mul_pkg::word_t result,
  input logic           ovf,
  input logic           sat_en,
  input logic           done,
  input logic           done_ovf,
  input mul_pkg::cnt_t  done_count,
  input logic           ovf_flag
);

  localparam int W = mul_pkg::WORD_WIDTH;

  // Operands of the request in flight as the requester presented them
  mul_pkg::word_t  cap_a;
  mul_pkg::word_t  cap_b;
  mul_pkg::dword_t full;
  logic            exp_ovf;

  // Previous req sample for spotting the first edge of a new request
  logic req_q;
  logic start;

  assign start   = req && !req_q;
  assign full    = mul_pkg::dword_t'(cap_a) * mul_pkg::dword_t'(cap_b);
  assign exp_ovf = |full[2*W-1:W];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q <= 1'b0;
    end
    else
    begin
      req_q <= req;
    end
  end

  // The requester holds the operands stable from the first edge that sees req
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      cap_a <= op_a;
      cap_b <= op_b;
    end
  end

  // A new request must wait until ack has dropped
  a_req_rule: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) |-> !ack)
  else
  begin
    $error("req rose while ack was still high");
    mul_unit_tb.assert_fails = mul_unit_tb.assert_fails + 1;
  end

  // ack goes high at the fifth edge after the edge that first sees req high
  // In sampled values the rise shows up MUL_LATENCY + 2 edges after the start
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) == $past(start, mul_pkg::MUL_LATENCY + 2))
  else
  begin
    $error("ack did not rise exactly 5 cycles after req was sampled high");
    mul_unit_tb.assert_fails = mul_unit_tb.assert_fails + 1;
  end

  // The result saturates only when the mode was on at the completing edge
  a_product: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> (ovf == exp_ovf) && (result ==
      (($past(sat_en) && exp_ovf) ? {W{1'b1}} : full[W-1:0])))
  else
  begin
    $error("result = 0x%0h and ovf = %0b do not match the product 0x%0h",
           $sampled(result), $sampled(ovf), $sampled(full));
    mul_unit_tb.assert_fails = mul_unit_tb.assert_fails + 1;
  end

  // Held req keeps the response frozen and allows no second completion
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ack && req |=> ack && $stable(result) && $stable(ovf) && !done)
  else
  begin
    $error("response changed or completed again while req was held");
    mul_unit_tb.assert_fails = mul_unit_tb.assert_fails + 1;
  end

  a_release: assert property (@(posedge clk) disable iff (!rst_n)
    ack && !req |=> !ack)
  else
  begin
    $error("ack did not fall one cycle after req was seen low");
    mul_unit_tb.assert_fails = mul_unit_tb.assert_fails + 1;
  end

  // Each completion bumps COUNT and an overflowing one sets the flag
  a_status: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> (done_count == $past(done_count) + mul_pkg::cnt_t'(1))
    && (ovf_flag || !$past(done_ovf)))
  else
  begin
    $error("COUNT or STATUS flag not updated after a completion");
    mul_unit_tb.assert_fails = mul_unit_tb.assert_fails + 1;
  end

endmodule

// ==== dv/mul_unit_tb.sv ====
/*
  Multiply unit testbench
  Four-phase requester and config bus host that walk the unit through
  small, random, saturating, held and status tests
*/

`timescale 1ns/10ps

module mul_unit_tb;

  // Some 240 requests at about ten cycles each, plus holds and config accesses
  localparam int MAX_CYCLES = 4000;

  logic               clk;
  logic               rst_n;
  logic               req;
  mul_pkg::word_t     op_a;
  mul_pkg::word_t     op_b;
  logic               ack;
  mul_pkg::word_t     result;
  logic               ovf;
  logic               cfg_wr;
  mul_pkg::cfg_addr_t cfg_addr;
  mul_pkg::word_t     cfg_wdata;
  mul_pkg::word_t     cfg_rdata;

  // The bound checker raises assert_fails on every failed assertion
  int read_errors;
  int assert_fails;
  int tests_run;
  int requests_done;
  int reads_done;
  int cycles;
  int hold;
  integer seed;

  // Our own copy of COUNT and the sticky flag
  mul_pkg::cnt_t model_count;
  logic          model_flag;

  // Overflowing pairs that run once with saturation on and once with it off
  mul_pkg::word_t ovf_a [8];
  mul_pkg::word_t ovf_b [8];

  mul_unit_top dut (.*);

  bind mul_unit_top mul_unit_asserts u_asserts (
    .*,
    .done_count (u_regs.done_count),
    .ovf_flag   (u_regs.ovf_flag)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog ends a run whose handshake never completes
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // One full four-phase transfer with req held for extra cycles after ack
  task automatic run_request(input mul_pkg::word_t a, input mul_pkg::word_t b, input int extra);
    mul_pkg::dword_t full;
    full = {{mul_pkg::WORD_WIDTH{1'b0}}, a} * {{mul_pkg::WORD_WIDTH{1'b0}}, b};
    @(posedge clk);
    op_a <= a;
    op_b <= b;
    req  <= 1'b1;
    while (!ack)
    begin
      @(posedge clk);
    end
    repeat (extra) @(posedge clk);
    req <= 1'b0;
    while (ack)
    begin
      @(posedge clk);
    end
    requests_done++;
    model_count = model_count + mul_pkg::cnt_t'(1);
    // The flag sticks as soon as any product spills into the high word
    if (|full[2*mul_pkg::WORD_WIDTH-1:mul_pkg::WORD_WIDTH])
    begin
      model_flag = 1'b1;
    end
  endtask

  task automatic cfg_write(input mul_pkg::cfg_addr_t addr, input mul_pkg::word_t data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr    <= 1'b0;
  endtask

  // Readback is combinational so it is settled one edge after the address
  task automatic cfg_check(input mul_pkg::cfg_addr_t addr, input mul_pkg::word_t expected,
                           input string name);
    @(posedge clk);
    cfg_addr <= addr;
    @(posedge clk);
    reads_done++;
    if (cfg_rdata !== expected)
    begin
      $display("error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, cfg_rdata, expected);
      read_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %0d %s finished, %0d failures so far", tests_run, name,
             read_errors + assert_fails);
  endtask

  initial
  begin
    seed = 75465;
    cycles = 0;
    read_errors = 0;
    assert_fails = 0;
    tests_run = 0;
    requests_done = 0;
    reads_done = 0;
    model_count = '0;
    model_flag = 1'b0;
    rst_n = 1'b0;
    req = 1'b0;
    op_a = '0;
    op_b = '0;
    cfg_wr = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Zero, one and single digit operands never overflow
    run_request(32'd0, 32'h1234_5678, 0);
    run_request(32'd1, 32'hDEAD_BEEF, 0);
    run_request(32'd15, 32'd15, 0);
    run_request(32'h0000_FFFF, 32'h0000_FFFF, 0);
    run_request(32'd7, 32'd0, 0);
    report_test("small_operands");

    for (int i = 0; i < 200; i++)
    begin
      run_request($random(seed), $random(seed), 0);
    end
    cfg_check(mul_pkg::REG_COUNT, mul_pkg::word_t'(model_count), "cfg_rdata COUNT");
    cfg_check(mul_pkg::REG_STATUS, mul_pkg::word_t'(model_flag), "cfg_rdata STATUS");
    report_test("random_operands");

    // Top bits set on both sides guarantee a product of at least 2^61
    ovf_a[0] = 32'hFFFF_FFFF;
    ovf_b[0] = 32'd2;
    ovf_a[1] = 32'h0001_0000;
    ovf_b[1] = 32'h0001_0000;
    for (int i = 2; i < 8; i++)
    begin
      ovf_a[i] = $random(seed) | 32'h8000_0000;
      ovf_b[i] = $random(seed) | 32'h4000_0000;
    end
    cfg_write(mul_pkg::REG_CTRL, 32'd1);
    cfg_check(mul_pkg::REG_CTRL, 32'd1, "cfg_rdata CTRL");
    for (int i = 0; i < 8; i++)
    begin
      run_request(ovf_a[i], ovf_b[i], 0);
    end
    cfg_write(mul_pkg::REG_CTRL, 32'd0);
    cfg_check(mul_pkg::REG_CTRL, 32'd0, "cfg_rdata CTRL");
    for (int i = 0; i < 8; i++)
    begin
      run_request(ovf_a[i], ovf_b[i], 0);
    end
    report_test("saturation");

    for (int i = 0; i < 12; i++)
    begin
      hold = $unsigned($random(seed)) % 21;
      run_request($random(seed), $random(seed), hold);
    end
    report_test("protocol_hold");

    // A zero write leaves the flag alone and a one clears it
    cfg_check(mul_pkg::REG_STATUS, mul_pkg::word_t'(model_flag), "cfg_rdata STATUS");
    cfg_write(mul_pkg::REG_STATUS, 32'd0);
    cfg_check(mul_pkg::REG_STATUS, mul_pkg::word_t'(model_flag), "cfg_rdata STATUS");
    cfg_write(mul_pkg::REG_STATUS, 32'd1);
    model_flag = 1'b0;
    cfg_check(mul_pkg::REG_STATUS, 32'd0, "cfg_rdata STATUS");
    run_request(32'd3, 32'd5, 0);
    cfg_check(mul_pkg::REG_STATUS, mul_pkg::word_t'(model_flag), "cfg_rdata STATUS");
    run_request(32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
    cfg_check(mul_pkg::REG_STATUS, mul_pkg::word_t'(model_flag), "cfg_rdata STATUS");
    cfg_check(mul_pkg::REG_COUNT, mul_pkg::word_t'(model_count), "cfg_rdata COUNT");
    report_test("status_block");

    repeat (4) @(posedge clk);
    $display("%0d tests, %0d requests, %0d reads, %0d read errors, %0d assertion failures",
             tests_run, requests_done, reads_done, read_errors, assert_fails);
    if (read_errors == 0 && assert_fails == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== build.f ====
design/mul_pkg.sv
design/nibble_multiplier.sv
design/mul_req_ctrl.sv
design/mul_config_regs.sv
design/mul_unit_top.sv
dv/mul_unit_asserts.sv
dv/mul_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the multiply unit testbench with Verilator, run it and scan the log.
# The runtime error limit lets the run go on past a failed assertion so the
# testbench can print its summary.
verilator --binary --assert --timescale 1ns/10ps --top-module mul_unit_tb \
  -f build.f -o mul_unit_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/mul_unit_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && exit 0 || exit 1
